// File: verilog/aes_pkg.sv
package aes_pkg;

  typedef logic [127:0] aes_block_t;
  typedef logic [127:0] aes_key_t;
  typedef logic [31:0]  aes_word_t;
  typedef logic [7:0]   aes_byte_t;

  localparam int AES_ROUNDS = 10;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } aes_state_e;

  // Forward S-box, entry 0 in the top byte.
  localparam logic [255:0][7:0] SBOX_TABLE = {
    128'h637c777b_f26b6fc5_3001672b_fed7ab76,
    128'hca82c97d_fa5947f0_add4a2af_9ca472c0,
    128'hb7fd9326_363ff7cc_34a5e5f1_71d83115,
    128'h04c723c3_1896059a_071280e2_eb27b275,
    128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84,
    128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf,
    128'hd0efaafb_434d3385_45f9027f_503c9fa8,
    128'h51a3408f_929d38f5_bcb6da21_10fff3d2,
    128'hcd0c13ec_5f974417_c4a77e3d_645d1973,
    128'h60814fdc_222a9088_46eeb814_de5e0bdb,
    128'he0323a0a_4906245c_c2d3ac62_9195e479,
    128'he7c8376d_8dd54ea9_6c56f4ea_657aae08,
    128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a,
    128'h703eb566_4803f60e_613557b9_86c11d9e,
    128'he1f89811_69d98e94_9b1e87e9_ce5528df,
    128'h8ca1890d_bfe64268_41992d0f_b054bb16
  };

  function automatic aes_byte_t sbox(input aes_byte_t b);
    return SBOX_TABLE[8'd255 - b];
  endfunction

  // Multiply by x in GF(2^8), reduced by the AES polynomial.
  function automatic aes_byte_t xtime(input aes_byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

endpackage

// File: verilog/wb_regs_pkg.sv
package wb_regs_pkg;

  typedef logic [31:0] wb_data_t;
  typedef logic [31:0] wb_addr_t;

  // Word addresses, taken from wb_adr_i[4:0].
  localparam logic [4:0] REG_CTRL   = 5'd0;
  localparam logic [4:0] REG_PT0    = 5'd1;   // Most significant plaintext word.
  localparam logic [4:0] REG_PT1    = 5'd2;
  localparam logic [4:0] REG_PT2    = 5'd3;
  localparam logic [4:0] REG_PT3    = 5'd4;
  localparam logic [4:0] REG_KEY0   = 5'd5;   // Most significant key word.
  localparam logic [4:0] REG_KEY1   = 5'd6;
  localparam logic [4:0] REG_KEY2   = 5'd7;
  localparam logic [4:0] REG_KEY3   = 5'd8;
  localparam logic [4:0] REG_STATUS = 5'd9;
  localparam logic [4:0] REG_CT0    = 5'd10;
  localparam logic [4:0] REG_CT1    = 5'd11;
  localparam logic [4:0] REG_CT2    = 5'd12;
  localparam logic [4:0] REG_CT3    = 5'd13;
  localparam logic [4:0] REG_LAST   = 5'd13;

endpackage

// File: verilog/aes_core_if.sv
`timescale 1ns/1ps

interface aes_core_if;
  import aes_pkg::*;

  aes_block_t pt;
  aes_key_t   key;
  logic       start;     // Level, the core acts on its rising edge.
  aes_block_t ct;
  logic       ct_valid;  // Level, held until the next start edge.

  modport regs (
    output pt, key, start,
    input  ct, ct_valid
  );

  modport core (
    input  pt, key, start,
    output ct, ct_valid
  );

endinterface

// File: verilog/aes_round.sv
`timescale 1ns/1ps

module aes_round (
  input  aes_pkg::aes_block_t state_i,
  input  aes_pkg::aes_key_t   round_key_i,
  input  logic                final_i,
  output aes_pkg::aes_block_t state_o
);
  import aes_pkg::*;

  aes_byte_t  sub_b [16];
  aes_byte_t  shf_b [16];
  aes_byte_t  mix_b [16];
  aes_block_t rnd_blk;

  // Byte i sits at bits [127-8i -: 8], column c holds bytes 4c to 4c+3.
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      sub_b[i] = sbox(state_i[127 - 8*i -: 8]);
    end
  end

  // Row r rotates left by r columns.
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shf_b[4*c + r] = sub_b[4*((c + r) % 4) + r];
      end
    end
  end

  // MixColumns as a ^ t ^ 2(a ^ next), t being the XOR of the column.
  always_comb begin
    aes_byte_t col_x;
    for (int c = 0; c < 4; c++) begin
      col_x = shf_b[4*c] ^ shf_b[4*c + 1] ^ shf_b[4*c + 2] ^ shf_b[4*c + 3];
      for (int r = 0; r < 4; r++) begin
        mix_b[4*c + r] = shf_b[4*c + r] ^ col_x ^
                         xtime(shf_b[4*c + r] ^ shf_b[4*c + (r + 1) % 4]);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 16; i++) begin
      rnd_blk[127 - 8*i -: 8] = final_i ? shf_b[i] : mix_b[i];  // Last round has no mix.
    end
  end

  assign state_o = rnd_blk ^ round_key_i;

endmodule

// File: verilog/aes_key_expand.sv
`timescale 1ns/1ps

module aes_key_expand (
  input  aes_pkg::aes_key_t  key_i,
  input  aes_pkg::aes_byte_t rcon_i,
  output aes_pkg::aes_key_t  key_o
);
  import aes_pkg::*;

  aes_word_t w0;
  aes_word_t w1;
  aes_word_t w2;
  aes_word_t w3;
  aes_word_t rot_w;
  aes_word_t sub_w;
  aes_word_t n0;
  aes_word_t n1;
  aes_word_t n2;
  aes_word_t n3;

  assign w0 = key_i[127:96];
  assign w1 = key_i[95:64];
  assign w2 = key_i[63:32];
  assign w3 = key_i[31:0];

  assign rot_w = {w3[23:0], w3[31:24]};  // RotWord.

  // SubWord, then the round constant on the top byte.
  assign sub_w = {sbox(rot_w[31:24]) ^ rcon_i,
                  sbox(rot_w[23:16]),
                  sbox(rot_w[15:8]),
                  sbox(rot_w[7:0])};

  assign n0 = w0 ^ sub_w;
  assign n1 = w1 ^ n0;
  assign n2 = w2 ^ n1;
  assign n3 = w3 ^ n2;

  assign key_o = {n0, n1, n2, n3};

endmodule

// File: verilog/aes_128.sv
`timescale 1ns/1ps

module aes_128 (
  input  logic     wb_clk_i,
  input  logic     wb_rst_i,
  aes_core_if.core core
);
  import aes_pkg::*;

  aes_state_e fsm_q;
  logic       start_q;
  logic       start_edge;
  logic [3:0] rnd_q;
  logic       last_rnd;
  logic       ct_valid_q;
  aes_block_t state_q;
  aes_block_t state_next;
  aes_key_t   rkey_q;
  aes_key_t   rkey_next;
  aes_byte_t  rcon_q;

  assign start_edge = core.start & ~start_q;
  assign last_rnd   = (rnd_q == 4'(AES_ROUNDS));

  aes_key_expand aes_key_expand_inst (
    .key_i  (rkey_q),
    .rcon_i (rcon_q),
    .key_o  (rkey_next)
  );

  aes_round aes_round_inst (
    .state_i     (state_q),
    .round_key_i (rkey_next),
    .final_i     (last_rnd),
    .state_o     (state_next)
  );

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      fsm_q      <= IDLE;
      start_q    <= 1'b0;
      rnd_q      <= 4'd0;
      ct_valid_q <= 1'b0;
      state_q    <= '0;
    end else begin
      start_q <= core.start;
      case (fsm_q)
        IDLE, DONE: begin
          if (start_edge) begin
            fsm_q      <= RUN;
            rnd_q      <= 4'd1;
            ct_valid_q <= 1'b0;
            state_q    <= core.pt ^ core.key;  // Initial AddRoundKey.
          end else if (fsm_q == DONE) begin
            ct_valid_q <= 1'b1;
          end
        end
        RUN: begin
          state_q <= state_next;
          if (last_rnd) begin
            fsm_q <= DONE;
          end else begin
            rnd_q <= rnd_q + 4'd1;
          end
        end
        default: fsm_q <= IDLE;
      endcase
    end
  end

  // Round key and rcon advance together, one step per round.
  always_ff @(posedge wb_clk_i) begin
    if (fsm_q != RUN && start_edge) begin
      rkey_q <= core.key;
      rcon_q <= 8'h01;
    end else if (fsm_q == RUN) begin
      rkey_q <= rkey_next;
      rcon_q <= xtime(rcon_q);
    end
  end

  assign core.ct       = state_q;
  assign core.ct_valid = ct_valid_q;

  a_rnd_bound: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (fsm_q == RUN) |-> (rnd_q <= 4'(AES_ROUNDS)));

endmodule

// File: verilog/aes_wb_regs.sv
`timescale 1ns/1ps

module aes_wb_regs (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  wb_regs_pkg::wb_addr_t wb_adr_i,
  input  wb_regs_pkg::wb_data_t wb_dat_i,
  input  logic                  wb_we_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  output wb_regs_pkg::wb_data_t wb_dat_o,
  output logic                  wb_ack_o,
  output logic                  wb_err_o,
  aes_core_if.regs              core
);
  import wb_regs_pkg::*;

  logic [4:0] word_idx;
  logic       req;
  logic       mapped;
  logic       wr_req;
  logic       start_q;
  wb_data_t   pt_q [4];
  wb_data_t   key_q [4];
  wb_data_t   rd_data;

  assign word_idx = wb_adr_i[4:0];
  assign mapped   = (word_idx <= REG_LAST);

  // A request already answered waits one cycle before it counts again.
  assign req    = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o;
  assign wr_req = req & wb_we_i & mapped;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      start_q <= 1'b0;
      for (int i = 0; i < 4; i++) begin
        pt_q[i]  <= '0;
        key_q[i] <= '0;
      end
    end else if (wr_req) begin
      case (word_idx)
        REG_CTRL: start_q <= wb_dat_i[0];
        REG_PT0, REG_PT1, REG_PT2, REG_PT3:
          pt_q[2'(word_idx - REG_PT0)] <= wb_dat_i;
        REG_KEY0, REG_KEY1, REG_KEY2, REG_KEY3:
          key_q[2'(word_idx - REG_KEY0)] <= wb_dat_i;
        default: ;  // Status and ciphertext are read only.
      endcase
    end
  end

  always_comb begin
    case (word_idx)
      REG_CTRL:   rd_data = {31'b0, start_q};
      REG_PT0, REG_PT1, REG_PT2, REG_PT3:
        rd_data = pt_q[2'(word_idx - REG_PT0)];
      REG_KEY0, REG_KEY1, REG_KEY2, REG_KEY3:
        rd_data = key_q[2'(word_idx - REG_KEY0)];
      REG_STATUS: rd_data = {31'b0, core.ct_valid};
      REG_CT0:    rd_data = core.ct[127:96];
      REG_CT1:    rd_data = core.ct[95:64];
      REG_CT2:    rd_data = core.ct[63:32];
      REG_CT3:    rd_data = core.ct[31:0];
      default:    rd_data = '0;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      wb_ack_o <= req & mapped;
      wb_err_o <= req & ~mapped;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (req && !wb_we_i) begin
      wb_dat_o <= rd_data;
    end
  end

  // Word 0 is the most significant.
  assign core.pt    = {pt_q[0], pt_q[1], pt_q[2], pt_q[3]};
  assign core.key   = {key_q[0], key_q[1], key_q[2], key_q[3]};
  assign core.start = start_q;

  a_ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(wb_ack_o && wb_err_o));

  a_single_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (wb_ack_o || wb_err_o) |=> !(wb_ack_o || wb_err_o));

endmodule

// File: verilog/aes_top.sv
`timescale 1ns/1ps

module aes_top (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  wb_regs_pkg::wb_addr_t wb_adr_i,
  input  wb_regs_pkg::wb_data_t wb_dat_i,
  input  logic                  wb_we_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  output wb_regs_pkg::wb_data_t wb_dat_o,
  output logic                  wb_ack_o,
  output logic                  wb_err_o
);

  aes_core_if aes_core_if_inst ();

  // Register file on the bus side.
  aes_wb_regs aes_wb_regs_inst (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_we_i  (wb_we_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .core     (aes_core_if_inst.regs)
  );

  // Iterative encryption engine.
  aes_128 aes_128_inst (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .core     (aes_core_if_inst.core)
  );

endmodule

// File: verification/tb_aes_top.sv
`timescale 1ns/1ps

module tb_aes_top;
  import aes_pkg::*;
  import wb_regs_pkg::*;

  logic     wb_clk_i;
  logic     wb_rst_i;
  wb_addr_t wb_adr_i;
  wb_data_t wb_dat_i;
  logic     wb_we_i;
  logic     wb_cyc_i;
  logic     wb_stb_i;
  wb_data_t wb_dat_o;
  logic     wb_ack_o;
  logic     wb_err_o;

  logic [15:0] lfsr_q;
  wb_data_t    regs_exp [32];  // Expected read value per word index.

  aes_top aes_top_inst (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_we_i  (wb_we_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #10 wb_clk_i = ~wb_clk_i;
  end

  // Taps 16, 14, 13 and 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_word(output wb_data_t w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w = {w[30:0], lfsr_q[0]};  // One step per bit.
    end
  endtask

  task automatic stop_run();
    $display("Regression failed");
    $fatal(1, "stopping at first error");
  endtask

  // One classic cycle, held until ack or err comes back.
  task automatic bus_cycle(input logic [4:0] idx, input logic we, input wb_data_t wdata,
                           output wb_data_t rdata, output logic ack, output logic err);
    int cnt;
    cnt = 0;
    wb_adr_i = {27'd0, idx};
    wb_dat_i = wdata;
    wb_we_i  = we;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    @(posedge wb_clk_i);
    #1;
    while (!wb_ack_o && !wb_err_o) begin
      cnt++;
      if (cnt == 20) begin
        $display("Bus timeout: word %0d gave no ack and no err within 20 cycles", idx);
        stop_run();
      end
      @(posedge wb_clk_i);
      #1;
    end
    rdata = wb_dat_o;
    ack   = wb_ack_o;
    err   = wb_err_o;
    #1;  // Back on the drive point, 2 ns after the edge.
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [4:0] idx, input wb_data_t data,
                          output logic ack, output logic err);
    wb_data_t rd_unused;
    bus_cycle(idx, 1'b1, data, rd_unused, ack, err);
  endtask

  task automatic wb_read(input logic [4:0] idx, output wb_data_t data,
                         output logic ack, output logic err);
    bus_cycle(idx, 1'b0, '0, data, ack, err);
  endtask

  task automatic check_resp(input logic [4:0] idx, input logic ack, input logic err,
                            input logic exp_err);
    assert (ack == !exp_err && err == exp_err) else begin
      $display("FAILED at %0t: word %0d answered ack=%0b err=%0b, expected err=%0b",
               $time, idx, ack, err, exp_err);
      stop_run();
    end
  endtask

  task automatic write_reg(input logic [4:0] idx, input wb_data_t data);
    logic ack;
    logic err;
    wb_write(idx, data, ack, err);
    check_resp(idx, ack, err, 1'b0);
    if (idx == REG_CTRL) begin
      regs_exp[idx] = {31'd0, data[0]};
    end else if (idx <= REG_KEY3) begin
      regs_exp[idx] = data;  // Status and ciphertext ignore writes.
    end
  endtask

  task automatic read_check(input logic [4:0] idx, input wb_data_t exp);
    wb_data_t got;
    logic     ack;
    logic     err;
    wb_read(idx, got, ack, err);
    check_resp(idx, ack, err, 1'b0);
    assert (got === exp) else begin
      $display("FAILED at %0t: word %0d read %h, expected %h", $time, idx, got, exp);
      stop_run();
    end
  endtask

  task automatic check_all_regs();
    for (int i = 0; i <= int'(REG_LAST); i++) begin
      read_check(5'(i), regs_exp[5'(i)]);
    end
  endtask

  task automatic wait_valid();
    wb_data_t st;
    logic     ack;
    logic     err;
    int       polls;
    polls = 0;
    wb_read(REG_STATUS, st, ack, err);
    check_resp(REG_STATUS, ack, err, 1'b0);
    while (st[0] !== 1'b1) begin
      polls++;
      if (polls == 50) begin
        $display("Status never showed ct_valid within 50 polls");
        stop_run();
      end
      wb_read(REG_STATUS, st, ack, err);
      check_resp(REG_STATUS, ack, err, 1'b0);
    end
  endtask

  task automatic test_reset_values();
    check_all_regs();
  endtask

  task automatic test_operand_regs();
    wb_data_t w;
    for (int i = int'(REG_PT0); i <= int'(REG_KEY3); i++) begin
      rand_word(w);
      write_reg(5'(i), w);
    end
    rand_word(w);
    write_reg(REG_CT0, w);
    rand_word(w);
    write_reg(REG_STATUS, w);
    check_all_regs();
  endtask

  task automatic run_vector(input aes_block_t key, input aes_block_t pt, input aes_block_t ct);
    write_reg(REG_CTRL, 32'd0);
    for (int w = 0; w < 4; w++) begin
      write_reg(5'(int'(REG_KEY0) + w), key[127 - 32*w -: 32]);
      write_reg(5'(int'(REG_PT0) + w), pt[127 - 32*w -: 32]);
    end
    write_reg(REG_CTRL, 32'd1);
    read_check(REG_STATUS, 32'd0);  // Start edge has cleared the flag.
    wait_valid();
    regs_exp[REG_STATUS] = 32'd1;
    for (int w = 0; w < 4; w++) begin
      regs_exp[5'(int'(REG_CT0) + w)] = ct[127 - 32*w -: 32];
    end
    check_all_regs();
  endtask

  task automatic test_unmapped();
    wb_data_t w;
    wb_data_t got;
    logic     ack;
    logic     err;
    for (int i = int'(REG_LAST) + 1; i < 32; i++) begin
      rand_word(w);
      wb_write(5'(i), w, ack, err);
      check_resp(5'(i), ack, err, 1'b1);
      wb_read(5'(i), got, ack, err);
      check_resp(5'(i), ack, err, 1'b1);
    end
    check_all_regs();
  endtask

  task automatic test_start_no_edge();
    write_reg(REG_CTRL, 32'd1);
    for (int i = 0; i < 8; i++) begin
      read_check(REG_STATUS, 32'd1);  // Spans more than one encryption time.
    end
    check_all_regs();
  endtask

  initial begin
    wb_rst_i = 1'b1;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_we_i  = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    lfsr_q   = 16'd35526;
    for (int i = 0; i < 32; i++) begin
      regs_exp[5'(i)] = '0;
    end
    repeat (3) @(posedge wb_clk_i);
    #2;
    wb_rst_i = 1'b0;

    test_reset_values();
    test_operand_regs();
    run_vector(128'h000102030405060708090a0b0c0d0e0f,
               128'h00112233445566778899aabbccddeeff,
               128'h69c4e0d86a7b0430d8cdb78070b4c55a);
    run_vector(128'h2b7e151628aed2a6abf7158809cf4f3c,
               128'h3243f6a8885a308d313198a2e0370734,
               128'h3925841d02dc09fbdc118597196a0b32);
    test_unmapped();
    test_start_no_edge();

    $display("Regression passed");
    $finish;
  end

endmodule

// File: tb.f
verilog/aes_pkg.sv
verilog/wb_regs_pkg.sv
verilog/aes_core_if.sv
verilog/aes_round.sv
verilog/aes_key_expand.sv
verilog/aes_128.sv
verilog/aes_wb_regs.sv
verilog/aes_top.sv
verification/tb_aes_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the AES testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module tb_aes_top || exit 1
out="$(./obj_dir/Vtb_aes_top 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Regression passed" && exit 0 || exit 1
